// File: include/ps2_key_consts.svh
`ifndef PS2_KEY_CONSTS_SVH
`define PS2_KEY_CONSTS_SVH

// Spacebar make code, set 2
`define SC_SPACE 8'h29
// Prefix that marks the next byte as a key release
`define SC_BREAK 8'hF0

// Start, eight data bits, parity, stop
`define PS2_FRAME_BITS 11

// Scan code buffer between receiver and decoder
`define SCAN_FIFO_DEPTH 4
`define SCAN_FIFO_AW 2

// Flip-flops per PS/2 line before any logic looks at it
`define PS2_SYNC_STAGES 3

`endif

// File: design/ps2_key_pkg.sv
package ps2_key_pkg;

    // One byte as delivered by the keyboard
    typedef logic [7:0] scan_code_t;

    // Bit position inside an 11-bit frame
    // Start bit is 0, stop bit is 10
    typedef logic [3:0] frame_count_t;

    // Receiver FSM states
    typedef enum logic [1:0] {
        // Waiting for a start bit
        rx_idle,
        // Collecting data, parity and stop bits
        rx_shifting,
        // Frame complete, one cycle to report it
        rx_done
    } rx_state_t;

endpackage

// File: design/ps2_rx.sv
`include "ps2_key_consts.svh"

module ps2_rx (
    input  logic                   CLOCK_50,
    input  logic                   reset,
    input  logic                   PS2_CLK,
    input  logic                   PS2_DAT,
    output ps2_key_pkg::scan_code_t scan_code,
    output logic                   scan_valid,
    output logic                   frame_error
);

    import ps2_key_pkg::*;

    // Both lines are asynchronous to CLOCK_50
    logic [`PS2_SYNC_STAGES-1:0] clk_sync;
    logic [`PS2_SYNC_STAGES-1:0] dat_sync;
    // Previous synchronized keyboard clock
    logic clk_last;
    logic fall_edge;
    logic dat_bit;

    rx_state_t    state;
    frame_count_t bit_count;
    // Data bits 7..0, then parity, then stop, after ten shifts
    logic [9:0]   frame_bits;
    logic         parity_ok;
    logic         stop_ok;

    // Lines idle high, so the chains reset to ones
    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_last <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[`PS2_SYNC_STAGES-2:0], PS2_CLK};
            dat_sync <= {dat_sync[`PS2_SYNC_STAGES-2:0], PS2_DAT};
            clk_last <= clk_sync[`PS2_SYNC_STAGES-1];
        end
    end

    // Keyboard changes data on rising edge, we sample on falling edge
    assign fall_edge = clk_last & ~clk_sync[`PS2_SYNC_STAGES-1];
    assign dat_bit   = dat_sync[`PS2_SYNC_STAGES-1];

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            state     <= rx_idle;
            bit_count <= '0;
        end else begin
            case (state)
                rx_idle: begin
                    // Start bit must be low, anything else is noise
                    if (fall_edge && !dat_bit) begin
                        state     <= rx_shifting;
                        bit_count <= frame_count_t'(1);
                    end
                end
                rx_shifting: begin
                    if (fall_edge) begin
                        bit_count <= bit_count + frame_count_t'(1);
                        // Stop bit is the last one in the frame
                        if (bit_count == frame_count_t'(`PS2_FRAME_BITS - 1)) begin
                            state <= rx_done;
                        end
                    end
                end
                rx_done: begin
                    // Report lasts exactly one cycle
                    state     <= rx_idle;
                    bit_count <= '0;
                end
                default: begin
                    state <= rx_idle;
                end
            endcase
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge CLOCK_50) begin
        if (state == rx_shifting && fall_edge) begin
            frame_bits <= {dat_bit, frame_bits[9:1]};
        end
    end

    // Odd parity over data plus parity bit
    assign parity_ok = ^frame_bits[8:0];
    assign stop_ok   = frame_bits[9];

    assign scan_code   = frame_bits[7:0];
    // Either strobe, never both
    assign scan_valid  = (state == rx_done) && parity_ok && stop_ok;
    assign frame_error = (state == rx_done) && !(parity_ok && stop_ok);

endmodule

// File: design/scan_fifo.sv
`include "ps2_key_consts.svh"

module scan_fifo (
    input  logic                   CLOCK_50,
    input  logic                   reset,
    input  logic                   push,
    input  ps2_key_pkg::scan_code_t push_data,
    input  logic                   pop,
    output ps2_key_pkg::scan_code_t fifo_data,
    output logic                   fifo_empty
);

    import ps2_key_pkg::*;

    // One extra bit so a full buffer is distinct from an empty one
    localparam int unsigned cnt_w = `SCAN_FIFO_AW + 1;

    scan_code_t mem [`SCAN_FIFO_DEPTH];

    logic [`SCAN_FIFO_AW-1:0] wr_ptr;
    logic [`SCAN_FIFO_AW-1:0] rd_ptr;
    logic [cnt_w-1:0]         count;
    logic                     full;
    logic                     do_push;
    logic                     do_pop;

    assign full       = (count == cnt_w'(`SCAN_FIFO_DEPTH));
    assign fifo_empty = (count == '0);

    // Push into a full buffer is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !fifo_empty;

    // Storage only, pointers say what is valid
    always_ff @(posedge CLOCK_50) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Depth is a power of two, pointers wrap by themselves
    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head entry, valid whenever not empty
    assign fifo_data = mem[rd_ptr];

endmodule

// File: design/space_key_detector.sv
`include "ps2_key_consts.svh"

module space_key_detector (
    input  logic                   CLOCK_50,
    input  logic                   reset,
    input  ps2_key_pkg::scan_code_t fifo_data,
    input  logic                   fifo_empty,
    output logic                   fifo_pop,
    output logic                   space_pressed_pulse,
    output logic                   space_is_down
);

    // Set after F0, cleared by the byte that follows
    logic break_seen;

    // Always ready, take a byte whenever one is there
    assign fifo_pop = !fifo_empty;

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            break_seen          <= 1'b0;
            space_pressed_pulse <= 1'b0;
            space_is_down       <= 1'b0;
        end else begin
            // Pulse is one clock wide
            space_pressed_pulse <= 1'b0;

            if (fifo_pop) begin
                if (fifo_data == `SC_BREAK) begin
                    break_seen <= 1'b1;
                end else if (break_seen) begin
                    // Byte after F0 names the released key
                    break_seen <= 1'b0;
                    if (fifo_data == `SC_SPACE) begin
                        space_is_down <= 1'b0;
                    end
                end else if (fifo_data == `SC_SPACE) begin
                    // Make code, typematic repeats pulse again
                    space_pressed_pulse <= 1'b1;
                    space_is_down       <= 1'b1;
                end
                // Other make codes and E0 prefixes fall through
            end
        end
    end

endmodule

// File: design/ps2_space_top.sv
module ps2_space_top (
    input  logic CLOCK_50,
    input  logic reset,
    input  logic PS2_CLK,
    input  logic PS2_DAT,
    output logic space_pressed_pulse,
    output logic space_is_down,
    output logic frame_error
);

    import ps2_key_pkg::*;

    // Receiver to FIFO
    scan_code_t scan_code;
    logic       scan_valid;

    // FIFO to decoder
    scan_code_t fifo_data;
    logic       fifo_empty;
    logic       fifo_pop;

    // Bad frames go straight out, nothing is pushed for them
    ps2_rx rx_i (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .PS2_CLK    (PS2_CLK),
        .PS2_DAT    (PS2_DAT),
        .scan_code  (scan_code),
        .scan_valid (scan_valid),
        .frame_error(frame_error)
    );

    scan_fifo fifo_i (
        .CLOCK_50  (CLOCK_50),
        .reset     (reset),
        .push      (scan_valid),
        .push_data (scan_code),
        .pop       (fifo_pop),
        .fifo_data (fifo_data),
        .fifo_empty(fifo_empty)
    );

    space_key_detector det_i (
        .CLOCK_50           (CLOCK_50),
        .reset              (reset),
        .fifo_data          (fifo_data),
        .fifo_empty         (fifo_empty),
        .fifo_pop           (fifo_pop),
        .space_pressed_pulse(space_pressed_pulse),
        .space_is_down      (space_is_down)
    );

endmodule

// File: verification/ps2_space_chk.sv
`include "ps2_key_consts.svh"

module ps2_space_chk (
    input logic CLOCK_50,
    input logic reset,
    input logic scan_valid,
    input logic frame_error,
    input logic fifo_pop,
    input logic fifo_empty,
    input logic space_pressed_pulse,
    input logic space_is_down
);

    localparam int unsigned occ_w = `SCAN_FIFO_AW + 1;

    // Shadow of the FIFO fill level, built from the strobes alone
    logic [occ_w-1:0] occupancy;
    logic             full;
    logic             pushed;

    assign full   = (occupancy == occ_w'(`SCAN_FIFO_DEPTH));
    assign pushed = scan_valid && !full;

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            occupancy <= '0;
        end else if (pushed && !fifo_pop) begin
            occupancy <= occupancy + occ_w'(1);
        end else if (fifo_pop && !pushed) begin
            occupancy <= occupancy - occ_w'(1);
        end
    end

    pulse_single: assert property (@(posedge CLOCK_50) disable iff (reset)
        space_pressed_pulse |=> !space_pressed_pulse)
        else $error("space_pressed_pulse high on two cycles in a row");

    strobe_exclusive: assert property (@(posedge CLOCK_50) disable iff (reset)
        !(scan_valid && frame_error))
        else $error("scan_valid and frame_error high together");

    no_push_full: assert property (@(posedge CLOCK_50) disable iff (reset)
        !(scan_valid && full))
        else $error("scan code pushed into a full FIFO");

    pulse_with_level: assert property (@(posedge CLOCK_50) disable iff (reset)
        space_pressed_pulse |-> space_is_down)
        else $error("space_pressed_pulse without space_is_down");

    // Empty flag must agree with the shadow count
    empty_match: assert property (@(posedge CLOCK_50) disable iff (reset)
        fifo_empty == (occupancy == '0))
        else $error("fifo_empty disagrees with pushes and pops");

endmodule

bind ps2_space_top ps2_space_chk chk_i (
    .CLOCK_50           (CLOCK_50),
    .reset              (reset),
    .scan_valid         (scan_valid),
    .frame_error        (frame_error),
    .fifo_pop           (fifo_pop),
    .fifo_empty         (fifo_empty),
    .space_pressed_pulse(space_pressed_pulse),
    .space_is_down      (space_is_down)
);

// File: verification/ps2_space_tb.sv
`include "ps2_key_consts.svh"

module ps2_space_tb;

    import ps2_key_pkg::*;

    localparam int num_tests = 8;
    // Rows times three frames of eleven bits, 16 clocks per bit, twice over
    localparam int cycle_limit = num_tests * 3 * `PS2_FRAME_BITS * 16 * 2;
    // Keyboard clock half period in system clocks
    localparam int half_bit = 8;
    // Margin after each frame, covers sync, FIFO and decoder delay
    localparam int settle_clocks = 20;

    logic CLOCK_50;
    logic reset;
    logic PS2_CLK;
    logic PS2_DAT;
    logic space_pressed_pulse;
    logic space_is_down;
    logic frame_error;

    // Stimulus table, one row per test
    string test_name [num_tests] = '{
        "space press", "space release", "other key make and break",
        "space typematic repeat", "release after repeat", "bad parity on space",
        "space press again", "random non-space bytes"
    };
    int         byte_count [num_tests] = '{1, 2, 3, 3, 2, 1, 1, 3};
    scan_code_t test_bytes [num_tests][3] = '{
        '{`SC_SPACE, 8'h00, 8'h00},
        '{`SC_BREAK, `SC_SPACE, 8'h00},
        '{8'h1C, `SC_BREAK, 8'h1C},
        '{`SC_SPACE, `SC_SPACE, `SC_SPACE},
        '{`SC_BREAK, `SC_SPACE, 8'h00},
        '{`SC_SPACE, 8'h00, 8'h00},
        '{`SC_SPACE, 8'h00, 8'h00},
        '{8'h00, 8'h00, 8'h00}
    };
    bit bad_parity [num_tests] = '{0, 0, 0, 0, 0, 1, 0, 0};
    bit use_random [num_tests] = '{0, 0, 0, 0, 0, 0, 0, 1};
    int exp_pulses [num_tests] = '{1, 0, 0, 3, 0, 0, 1, 0};
    // Level after the row, the bad frame leaves it where it was
    bit exp_level  [num_tests] = '{1, 0, 0, 1, 0, 0, 1, 1};
    int exp_errors [num_tests] = '{0, 0, 0, 0, 0, 1, 0, 0};

    int pulse_seen;
    int error_seen;
    int rx_seen;
    scan_code_t rx_code;
    int cycles = 0;
    int check_total = 0;
    int fails = 0;
    logic [31:0] lfsr_state = 32'heef9_c30a;

    ps2_space_top dut_i (
        .CLOCK_50           (CLOCK_50),
        .reset              (reset),
        .PS2_CLK            (PS2_CLK),
        .PS2_DAT            (PS2_DAT),
        .space_pressed_pulse(space_pressed_pulse),
        .space_is_down      (space_is_down),
        .frame_error        (frame_error)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    // Count strobes at the top-level ports
    always @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            pulse_seen <= 0;
            error_seen <= 0;
        end else begin
            if (space_pressed_pulse) pulse_seen <= pulse_seen + 1;
            if (frame_error) error_seen <= error_seen + 1;
        end
    end

    // Bytes the receiver pushes into the FIFO, last one kept
    always @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            rx_seen <= 0;
        end else if (dut_i.scan_valid) begin
            rx_seen <= rx_seen + 1;
            rx_code <= dut_i.scan_code;
        end
    end

    // Hung run guard
    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d clocks, the run did not finish", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit, spacebar and break codes are redrawn
    task automatic random_code(output scan_code_t code);
        code = 8'h00;
        do begin
            for (int b = 0; b < 8; b++) begin
                lfsr_state = lfsr_next(lfsr_state);
                code = {code[6:0], lfsr_state[0]};
            end
        end while (code == `SC_SPACE || code == `SC_BREAK);
    endtask

    task automatic check_level(input string name, input string what,
                               input logic exp, input logic act);
        check_total++;
        if (act !== exp) begin
            fails++;
            $display("[FAIL] %s: %s expected %0b, actual %0b", name, what, exp, act);
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp, input int act);
        check_total++;
        if (act != exp) begin
            fails++;
            $display("[FAIL] %s: %s expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    task automatic check_code(input string name, input scan_code_t exp, input scan_code_t act);
        check_total++;
        if (act !== exp) begin
            fails++;
            $display("[FAIL] %s: received byte expected %h, actual %h", name, exp, act);
        end
    endtask

    // Keyboard model, data changes while the keyboard clock is high
    task automatic send_frame(input string name, input scan_code_t code, input bit corrupt);
        logic [`PS2_FRAME_BITS-1:0] frame;
        int rx_before;
        frame[0] = 1'b0;
        frame[8:1] = code;
        // Odd parity, flipped on request
        frame[9] = ~(^code) ^ corrupt;
        frame[10] = 1'b1;
        rx_before = rx_seen;
        for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
            // Data moves one clock into the high half
            @(posedge CLOCK_50);
            PS2_DAT <= frame[i];
            repeat (half_bit - 1) @(posedge CLOCK_50);
            PS2_CLK <= 1'b0;
            repeat (half_bit) @(posedge CLOCK_50);
            PS2_CLK <= 1'b1;
        end
        @(posedge CLOCK_50);
        PS2_DAT <= 1'b1;
        repeat (settle_clocks) @(posedge CLOCK_50);
        // A bad frame never reaches the FIFO, a good one arrives once
        check_count(name, "received bytes", corrupt ? 0 : 1, rx_seen - rx_before);
        if (!corrupt) begin
            check_code(name, code, rx_code);
        end
    endtask

    initial begin
        int pulses_before;
        int errors_before;
        int fails_before;
        scan_code_t code;
        reset   = 1'b1;
        PS2_CLK = 1'b1;
        PS2_DAT = 1'b1;
        repeat (5) @(posedge CLOCK_50);
        reset <= 1'b0;
        repeat (2) @(posedge CLOCK_50);

        for (int t = 0; t < num_tests; t++) begin
            pulses_before = pulse_seen;
            errors_before = error_seen;
            fails_before  = fails;
            for (int k = 0; k < byte_count[t]; k++) begin
                if (use_random[t]) begin
                    random_code(code);
                end else begin
                    code = test_bytes[t][k];
                end
                send_frame(test_name[t], code, bad_parity[t]);
            end
            check_count(test_name[t], "pulses", exp_pulses[t], pulse_seen - pulses_before);
            check_level(test_name[t], "space_is_down", exp_level[t], space_is_down);
            check_count(test_name[t], "frame errors", exp_errors[t], error_seen - errors_before);
            if (fails == fails_before) begin
                $display("[ ok ] %s", test_name[t]);
            end else begin
                $display("[done] %s with %0d failed checks", test_name[t], fails - fails_before);
            end
        end

        $display("Tests: %0d, checks: %0d, failed checks: %0d", num_tests, check_total, fails);
        if (fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
design/ps2_key_pkg.sv
design/ps2_rx.sv
design/scan_fifo.sv
design/space_key_detector.sv
design/ps2_space_top.sv
verification/ps2_space_chk.sv
verification/ps2_space_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PS/2 spacebar testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
    --top-module ps2_space_tb -Mdir obj_dir -o ps2_space_sim -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ps2_space_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
    exit 1
fi
exit 0
